//--- condEval.sv
`timescale 1ns/10ps
`default_nettype none

module condEval (
    input  logic [2:0] cond,
    input  logic       carryFlag,
    input  logic       zeroFlag,
    input  logic       negativeFlag,
    output logic       condMet
);

    always_comb begin
        case (cond)
            3'd0:    condMet = 1'b1;            // always
            3'd1:    condMet = carryFlag;
            3'd2:    condMet = ~carryFlag;
            3'd3:    condMet = zeroFlag;
            3'd4:    condMet = ~zeroFlag;
            3'd5:    condMet = negativeFlag;
            3'd6:    condMet = 1'b0;            // never
            default: condMet = ~negativeFlag;   // code 7
        endcase
    end

endmodule

`default_nettype wire

//--- controlSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module controlSequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  cpuCtrlPkg::opcode_t   opcode,
    input  cpuCtrlPkg::aluMode_t  aluModeIn,
    input  cpuCtrlPkg::regSel_t   destSel,
    input  cpuCtrlPkg::regSel_t   srcSel,
    input  cpuCtrlPkg::regSel_t   pairSel,
    input  cpuCtrlPkg::pairStep_t pairStep,
    input  logic                  condMet,
    output cpuCtrlPkg::regSel_t   regFileOutBSelect,
    output logic                  regFileWriteEnable,
    output logic                  regFileIncPair,
    output logic                  regFileDecPair,
    output cpuCtrlPkg::aluSrcB_t  aluSrcBSelect,
    output cpuCtrlPkg::aluMode_t  aluMode,
    output cpuCtrlPkg::dMemData_t dMemDataSelect,
    output cpuCtrlPkg::dMemAddr_t dMemAddressSelect,
    output logic                  dMemWriteEn,
    output logic                  dMemReadEn,
    output logic                  flagEnable,
    output cpuCtrlPkg::iMemAddr_t iMemAddrSelect,
    output logic                  iMemReadEnable,
    output logic                  pcWriteEn
);

    cpuCtrlPkg::seqState_t state;
    cpuCtrlPkg::seqState_t nextState;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpuCtrlPkg::stFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        regFileOutBSelect  = destSel;
        regFileWriteEnable = 1'b0;
        regFileIncPair     = 1'b0;
        regFileDecPair     = 1'b0;
        aluSrcBSelect      = cpuCtrlPkg::srcBReg;
        aluMode            = cpuCtrlPkg::passB;
        dMemDataSelect     = cpuCtrlPkg::dataAluOut;
        dMemAddressSelect  = cpuCtrlPkg::addrRegPair;
        dMemWriteEn        = 1'b0;
        dMemReadEn         = 1'b0;
        flagEnable         = 1'b0;
        iMemAddrSelect     = cpuCtrlPkg::iAddrPcOut;
        iMemReadEnable     = 1'b0;
        pcWriteEn          = 1'b0;
        nextState          = cpuCtrlPkg::stFetch;

        case (state)
            cpuCtrlPkg::stFetch: begin
                case (opcode)
                    cpuCtrlPkg::opAluImm, cpuCtrlPkg::opAluReg: begin
                        if (opcode == cpuCtrlPkg::opAluImm) begin
                            aluSrcBSelect = cpuCtrlPkg::srcBImm8;
                        end else begin
                            regFileOutBSelect = srcSel;
                        end
                        aluMode            = aluModeIn;
                        regFileWriteEnable = 1'b1;
                        flagEnable         = 1'b1;
                        iMemReadEnable     = 1'b1;
                        pcWriteEn          = 1'b1;
                    end
                    cpuCtrlPkg::opIn: begin
                        dMemAddressSelect = cpuCtrlPkg::addrPortImm;
                        dMemReadEn        = 1'b1;
                        nextState         = cpuCtrlPkg::stReadWait;
                    end
                    cpuCtrlPkg::opOut: begin
                        dMemAddressSelect = cpuCtrlPkg::addrPortImm;
                        dMemWriteEn       = 1'b1;                // destSel data via pass B
                        iMemReadEnable    = 1'b1;
                        pcWriteEn         = 1'b1;
                    end
                    cpuCtrlPkg::opStore: begin
                        regFileOutBSelect = pairSel;
                        aluMode           = aluModeIn;
                        dMemWriteEn       = 1'b1;
                        regFileIncPair    = (pairStep == cpuCtrlPkg::stepInc);
                        regFileDecPair    = (pairStep == cpuCtrlPkg::stepDec);
                        iMemReadEnable    = 1'b1;
                        pcWriteEn         = 1'b1;
                    end
                    cpuCtrlPkg::opLoad: begin
                        regFileOutBSelect = pairSel;
                        aluMode           = aluModeIn;
                        dMemReadEn        = 1'b1;
                        nextState         = cpuCtrlPkg::stReadWait;
                    end
                    cpuCtrlPkg::opJmp: begin
                        if (condMet) begin
                            nextState = cpuCtrlPkg::stJumpTarget;
                        end else begin
                            iMemAddrSelect = cpuCtrlPkg::iAddrPcPlusOne;  // skip target word
                            iMemReadEnable = 1'b1;
                            pcWriteEn      = 1'b1;
                        end
                    end
                    cpuCtrlPkg::opCall: begin
                        regFileOutBSelect = cpuCtrlPkg::spLowReg;
                        if (condMet) begin
                            dMemDataSelect = cpuCtrlPkg::dataPcLow;       // push low byte first
                            dMemWriteEn    = 1'b1;
                            regFileDecPair = 1'b1;
                            nextState      = cpuCtrlPkg::stCallHigh;
                        end else begin
                            iMemAddrSelect = cpuCtrlPkg::iAddrPcPlusOne;
                            iMemReadEnable = 1'b1;
                            pcWriteEn      = 1'b1;
                        end
                    end
                    cpuCtrlPkg::opRet: begin
                        regFileOutBSelect = cpuCtrlPkg::spLowReg;
                        if (condMet) begin
                            dMemReadEn     = 1'b1;                        // pop return address
                            regFileIncPair = 1'b1;
                            nextState      = cpuCtrlPkg::stReadWait;
                        end else begin
                            iMemReadEnable = 1'b1;
                            pcWriteEn      = 1'b1;
                        end
                    end
                    cpuCtrlPkg::opHlt: begin
                        nextState = cpuCtrlPkg::stFetch;                  // pc frozen
                    end
                    default: begin                                       // nop
                        iMemReadEnable = 1'b1;
                        pcWriteEn      = 1'b1;
                    end
                endcase
            end
            cpuCtrlPkg::stReadWait: begin
                // fetch was stalled, so the word in iMemOut is still the same instruction
                dMemReadEn     = 1'b1;
                iMemReadEnable = 1'b1;
                pcWriteEn      = 1'b1;
                if (opcode == cpuCtrlPkg::opRet) begin
                    regFileOutBSelect = cpuCtrlPkg::spLowReg;
                    regFileIncPair    = 1'b1;
                    iMemAddrSelect    = cpuCtrlPkg::iAddrIMemOut;
                end else begin
                    regFileWriteEnable = 1'b1;                            // capture read data
                    if (opcode == cpuCtrlPkg::opIn) begin
                        dMemAddressSelect = cpuCtrlPkg::addrPortImm;
                    end else begin
                        regFileOutBSelect = pairSel;
                        aluMode           = aluModeIn;
                        regFileIncPair    = (pairStep == cpuCtrlPkg::stepInc);
                        regFileDecPair    = (pairStep == cpuCtrlPkg::stepDec);
                    end
                end
            end
            cpuCtrlPkg::stJumpTarget: begin
                iMemAddrSelect = cpuCtrlPkg::iAddrIMemOut;
                iMemReadEnable = 1'b1;
                pcWriteEn      = 1'b1;
            end
            default: begin                                               // stCallHigh
                regFileOutBSelect = cpuCtrlPkg::spLowReg;
                dMemDataSelect    = cpuCtrlPkg::dataPcHigh;
                dMemWriteEn       = 1'b1;
                regFileDecPair    = 1'b1;
                iMemAddrSelect    = cpuCtrlPkg::iAddrIMemOut;
                iMemReadEnable    = 1'b1;
                pcWriteEn         = 1'b1;
            end
        endcase

        // all enables stay low while in reset
        if (reset) begin
            regFileWriteEnable = 1'b0;
            regFileIncPair     = 1'b0;
            regFileDecPair     = 1'b0;
            dMemWriteEn        = 1'b0;
            dMemReadEn         = 1'b0;
            flagEnable         = 1'b0;
            iMemReadEnable     = 1'b0;
            pcWriteEn          = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- cpuControl.f
cpuCtrlPkg.sv
condEval.sv
instrDecode.sv
controlSequencer.sv
cpuControl.sv
cpuControlTb.sv

//--- cpuControl.sv
`timescale 1ns/10ps
`default_nettype none

module cpuControl (
    input  logic                  clk,
    input  logic                  reset,
    input  cpuCtrlPkg::instr_t    iMemOut,
    input  logic                  carryFlag,
    input  logic                  zeroFlag,
    input  logic                  negativeFlag,
    output cpuCtrlPkg::regSel_t   regFileOutBSelect,
    output logic                  regFileWriteEnable,
    output logic                  regFileIncPair,
    output logic                  regFileDecPair,
    output cpuCtrlPkg::aluSrcB_t  aluSrcBSelect,
    output cpuCtrlPkg::aluMode_t  aluMode,
    output cpuCtrlPkg::dMemData_t dMemDataSelect,
    output cpuCtrlPkg::dMemAddr_t dMemAddressSelect,
    output logic                  dMemWriteEn,
    output logic                  dMemReadEn,
    output logic                  flagEnable,
    output cpuCtrlPkg::iMemAddr_t iMemAddrSelect,
    output logic                  iMemReadEnable,
    output logic                  pcWriteEn
);

    logic                  condMet;
    cpuCtrlPkg::opcode_t   opcode;
    cpuCtrlPkg::aluMode_t  decAluMode;      // decoded mode before sequencing
    cpuCtrlPkg::regSel_t   destSel;
    cpuCtrlPkg::regSel_t   srcSel;
    cpuCtrlPkg::regSel_t   pairSel;
    cpuCtrlPkg::pairStep_t pairStep;

    condEval i_condEval (
        .cond         (iMemOut[cpuCtrlPkg::condLsb +: 3]),
        .carryFlag    (carryFlag),
        .zeroFlag     (zeroFlag),
        .negativeFlag (negativeFlag),
        .condMet      (condMet)
    );

    instrDecode i_instrDecode (
        .iMemOut  (iMemOut),
        .opcode   (opcode),
        .aluMode  (decAluMode),
        .destSel  (destSel),
        .srcSel   (srcSel),
        .pairSel  (pairSel),
        .pairStep (pairStep)
    );

    controlSequencer i_controlSequencer (
        .clk                (clk),
        .reset              (reset),
        .opcode             (opcode),
        .aluModeIn          (decAluMode),
        .destSel            (destSel),
        .srcSel             (srcSel),
        .pairSel            (pairSel),
        .pairStep           (pairStep),
        .condMet            (condMet),
        .regFileOutBSelect  (regFileOutBSelect),
        .regFileWriteEnable (regFileWriteEnable),
        .regFileIncPair     (regFileIncPair),
        .regFileDecPair     (regFileDecPair),
        .aluSrcBSelect      (aluSrcBSelect),
        .aluMode            (aluMode),
        .dMemDataSelect     (dMemDataSelect),
        .dMemAddressSelect  (dMemAddressSelect),
        .dMemWriteEn        (dMemWriteEn),
        .dMemReadEn         (dMemReadEn),
        .flagEnable         (flagEnable),
        .iMemAddrSelect     (iMemAddrSelect),
        .iMemReadEnable     (iMemReadEnable),
        .pcWriteEn          (pcWriteEn)
    );

endmodule

`default_nettype wire

//--- cpuControlTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuControlTb;

    localparam int halfPeriod = 10;
    localparam int cycleLimit = 1200;       // 6 tests x 40 words x 2 cycles, reset, margin

    // en holds wr, inc, dec, dWr, dRd, flag, iRd, pcWr from msb to lsb
    typedef struct packed {
        logic [7:0] en;
        logic [3:0] outB;
        logic       srcB;
        logic [3:0] mode;
        logic [1:0] dataSel;
        logic       addrSel;
        logic [1:0] iAddr;
        logic [1:0] nextState;
    } ctrl_t;

    logic                  clk;
    logic                  reset;
    cpuCtrlPkg::instr_t    iMemOut;
    logic                  carryFlag;
    logic                  zeroFlag;
    logic                  negativeFlag;
    cpuCtrlPkg::regSel_t   regFileOutBSelect;
    logic                  regFileWriteEnable;
    logic                  regFileIncPair;
    logic                  regFileDecPair;
    cpuCtrlPkg::aluSrcB_t  aluSrcBSelect;
    cpuCtrlPkg::aluMode_t  aluMode;
    cpuCtrlPkg::dMemData_t dMemDataSelect;
    cpuCtrlPkg::dMemAddr_t dMemAddressSelect;
    logic                  dMemWriteEn;
    logic                  dMemReadEn;
    logic                  flagEnable;
    cpuCtrlPkg::iMemAddr_t iMemAddrSelect;
    logic                  iMemReadEnable;
    logic                  pcWriteEn;

    logic [31:0]           lfsrState;
    cpuCtrlPkg::seqState_t modelState;      // expected sequencer state
    int                    cycleCount;
    int                    checks;
    int                    errors;

    cpuControl i_cpuControl (.*);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("run stopped after %0d cycles without finishing the tests", cycleCount);
            $display("** FAIL **");
            $finish;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic [15:0] randomBits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value     = {value[14:0], lfsrState[0]};
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'hA300_0000 : 32'h0);
        end
        return value;
    endfunction

    // random word of one instruction class
    function automatic cpuCtrlPkg::instr_t makeWord(input cpuCtrlPkg::opcode_t op);
        cpuCtrlPkg::instr_t word;
        logic [4:0]         subOp;
        logic [2:0]         aluCode;
        word  = randomBits(16);
        subOp = 5'd0;
        case (op)
            cpuCtrlPkg::opAluImm: begin
                aluCode   = randomBits(3) % 7;      // code 7 is not an alu op
                word[3:0] = {aluCode, 1'b1};
            end
            cpuCtrlPkg::opIn:     word[2:0] = 3'b010;
            cpuCtrlPkg::opOut:    word[2:0] = 3'b100;
            cpuCtrlPkg::opAluReg: subOp = 5'd1 + randomBits(4) % 12;
            cpuCtrlPkg::opStore:  subOp = 5'd13 + randomBits(2) % 3;
            cpuCtrlPkg::opLoad:   subOp = 5'd16 + randomBits(2) % 3;
            cpuCtrlPkg::opJmp:    subOp = 5'd22;
            cpuCtrlPkg::opCall:   subOp = 5'd23;
            cpuCtrlPkg::opRet:    subOp = 5'd24;
            default:              subOp = 5'd29;
        endcase
        if (subOp != 5'd0) begin
            word[7:0] = {subOp, 3'b000};
        end
        return word;
    endfunction

    function automatic ctrl_t expectedControls(input cpuCtrlPkg::opcode_t op,
            input cpuCtrlPkg::instr_t w, input logic taken, input cpuCtrlPkg::seqState_t st);
        ctrl_t      e;
        logic [1:0] step;                       // 1 inc, 2 dec
        e         = '0;
        e.outB    = w[15:12];
        e.mode    = cpuCtrlPkg::passB;
        e.dataSel = cpuCtrlPkg::dataAluOut;
        e.iAddr   = cpuCtrlPkg::iAddrPcOut;
        step      = w[7:3] - ((op == cpuCtrlPkg::opStore) ? 5'd13 : 5'd16);
        case (st)
            cpuCtrlPkg::stFetch: begin
                case (op)
                    cpuCtrlPkg::opAluImm: begin
                        e.en   = 8'b1000_0111;
                        e.srcB = cpuCtrlPkg::srcBImm8;
                        e.mode = {1'b0, w[3:1]};
                    end
                    cpuCtrlPkg::opAluReg: begin
                        e.en   = 8'b1000_0111;
                        e.outB = w[11:8];
                        e.mode = w[6:3];
                    end
                    cpuCtrlPkg::opIn: begin
                        e.en        = 8'b0000_1000;
                        e.addrSel   = cpuCtrlPkg::addrPortImm;
                        e.nextState = cpuCtrlPkg::stReadWait;
                    end
                    cpuCtrlPkg::opOut: begin
                        e.en      = 8'b0001_0011;
                        e.addrSel = cpuCtrlPkg::addrPortImm;
                    end
                    cpuCtrlPkg::opStore: begin
                        e.en   = {1'b0, step == 2'd1, step == 2'd2, 5'b10011};
                        e.outB = {w[11:9], 1'b0};
                        e.mode = cpuCtrlPkg::passA;
                    end
                    cpuCtrlPkg::opLoad: begin
                        e.en        = 8'b0000_1000;
                        e.outB      = {w[11:9], 1'b0};
                        e.mode      = cpuCtrlPkg::passA;
                        e.nextState = cpuCtrlPkg::stReadWait;
                    end
                    cpuCtrlPkg::opJmp: begin
                        e.en        = taken ? 8'b0 : 8'b0000_0011;
                        e.iAddr     = taken ? cpuCtrlPkg::iAddrPcOut : cpuCtrlPkg::iAddrPcPlusOne;
                        e.nextState = taken ? cpuCtrlPkg::stJumpTarget : cpuCtrlPkg::stFetch;
                    end
                    cpuCtrlPkg::opCall: begin
                        e.outB      = cpuCtrlPkg::spLowReg;
                        e.en        = taken ? 8'b0011_0000 : 8'b0000_0011;
                        e.dataSel   = taken ? cpuCtrlPkg::dataPcLow : cpuCtrlPkg::dataAluOut;
                        e.iAddr     = taken ? cpuCtrlPkg::iAddrPcOut : cpuCtrlPkg::iAddrPcPlusOne;
                        e.nextState = taken ? cpuCtrlPkg::stCallHigh : cpuCtrlPkg::stFetch;
                    end
                    cpuCtrlPkg::opRet: begin
                        e.outB      = cpuCtrlPkg::spLowReg;
                        e.en        = taken ? 8'b0100_1000 : 8'b0000_0011;
                        e.nextState = taken ? cpuCtrlPkg::stReadWait : cpuCtrlPkg::stFetch;
                    end
                    cpuCtrlPkg::opHlt: e.en = 8'b0;     // pc frozen
                    default:           e.en = 8'b0000_0011;
                endcase
            end
            cpuCtrlPkg::stReadWait: begin
                if (op == cpuCtrlPkg::opRet) begin
                    e.outB  = cpuCtrlPkg::spLowReg;
                    e.en    = 8'b0100_1011;
                    e.iAddr = cpuCtrlPkg::iAddrIMemOut;
                end else if (op == cpuCtrlPkg::opIn) begin
                    e.en      = 8'b1000_1011;
                    e.addrSel = cpuCtrlPkg::addrPortImm;
                end else begin                          // load
                    e.en   = {1'b1, step == 2'd1, step == 2'd2, 5'b01011};
                    e.outB = {w[11:9], 1'b0};
                    e.mode = cpuCtrlPkg::passA;
                end
            end
            cpuCtrlPkg::stJumpTarget: begin
                e.en    = 8'b0000_0011;
                e.iAddr = cpuCtrlPkg::iAddrIMemOut;
            end
            default: begin                              // second push of call
                e.outB    = cpuCtrlPkg::spLowReg;
                e.en      = 8'b0011_0011;
                e.dataSel = cpuCtrlPkg::dataPcHigh;
                e.iAddr   = cpuCtrlPkg::iAddrIMemOut;
            end
        endcase
        return e;
    endfunction

    task automatic checkField(input string name, input logic [7:0] expected,
            input logic [7:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkAll(input ctrl_t e, input logic enablesOnly);
        checkField("regFileWriteEnable", e.en[7], regFileWriteEnable);
        checkField("regFileIncPair", e.en[6], regFileIncPair);
        checkField("regFileDecPair", e.en[5], regFileDecPair);
        checkField("dMemWriteEn", e.en[4], dMemWriteEn);
        checkField("dMemReadEn", e.en[3], dMemReadEn);
        checkField("flagEnable", e.en[2], flagEnable);
        checkField("iMemReadEnable", e.en[1], iMemReadEnable);
        checkField("pcWriteEn", e.en[0], pcWriteEn);
        if (!enablesOnly) begin
            checkField("regFileOutBSelect", e.outB, regFileOutBSelect);
            checkField("aluSrcBSelect", e.srcB, aluSrcBSelect);
            checkField("aluMode", e.mode, aluMode);
            checkField("dMemDataSelect", e.dataSel, dMemDataSelect);
            checkField("dMemAddressSelect", e.addrSel, dMemAddressSelect);
            checkField("iMemAddrSelect", e.iAddr, iMemAddrSelect);
        end
    endtask

    // one word, held until the sequencer is back in fetch
    task automatic runInstruction(input cpuCtrlPkg::opcode_t op, input int holdCycles);
        cpuCtrlPkg::instr_t word;
        logic [7:0]         truth;
        ctrl_t              e;
        word = makeWord(op);
        for (int i = 0; i < holdCycles; i++) begin
            @(posedge clk);
            reset        <= 1'b0;
            iMemOut      <= word;
            carryFlag    <= randomBits(1);
            zeroFlag     <= randomBits(1);
            negativeFlag <= randomBits(1);
            do begin
                @(negedge clk);
                // condition table, code 0 at the lsb
                truth = {~negativeFlag, 1'b0, negativeFlag, ~zeroFlag, zeroFlag,
                         ~carryFlag, carryFlag, 1'b1};
                e = expectedControls(op, word, truth[word[15:13]], modelState);
                checkAll(e, 1'b0);
                modelState = cpuCtrlPkg::seqState_t'(e.nextState);
            end while (modelState != cpuCtrlPkg::stFetch);
        end
    endtask

    task automatic runTest(input string name, input cpuCtrlPkg::opcode_t opA,
            input cpuCtrlPkg::opcode_t opB, input cpuCtrlPkg::opcode_t opC);
        int                  startChecks;
        int                  startErrors;
        logic [1:0]          pick;
        cpuCtrlPkg::opcode_t op;
        startChecks = checks;
        startErrors = errors;
        repeat (40) begin
            pick = randomBits(2);
            op   = (pick == 2'd0) ? opA : (pick == 2'd1) ? opB : opC;
            runInstruction(op, (op == cpuCtrlPkg::opHlt) ? 3 : 1);
        end
        $display("%s: %0d checks, %0d errors", name, checks - startChecks, errors - startErrors);
    endtask

    initial begin
        reset        = 1'b1;
        iMemOut      = '0;
        carryFlag    = 1'b0;
        zeroFlag     = 1'b0;
        negativeFlag = 1'b0;
        lfsrState    = 32'h92e9a98b;
        modelState   = cpuCtrlPkg::stFetch;
        cycleCount   = 0;
        checks       = 0;
        errors       = 0;

        repeat (16) begin
            @(posedge clk);
            iMemOut <= randomBits(16);      // any word, enables stay low
            @(negedge clk);
            checkAll('0, 1'b1);
        end
        runInstruction(cpuCtrlPkg::opAluImm, 1);    // first word after reset
        $display("reset: %0d checks, %0d errors", checks, errors);

        runTest("alu operations", cpuCtrlPkg::opAluImm, cpuCtrlPkg::opAluReg,
                cpuCtrlPkg::opAluReg);
        runTest("jmp conditions", cpuCtrlPkg::opJmp, cpuCtrlPkg::opJmp, cpuCtrlPkg::opJmp);
        runTest("in and load", cpuCtrlPkg::opIn, cpuCtrlPkg::opLoad, cpuCtrlPkg::opLoad);
        runTest("call and ret", cpuCtrlPkg::opCall, cpuCtrlPkg::opRet, cpuCtrlPkg::opRet);
        runTest("out, store and hlt", cpuCtrlPkg::opOut, cpuCtrlPkg::opStore,
                cpuCtrlPkg::opHlt);

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cpuCtrlPkg.sv
`default_nettype none

package cpuCtrlPkg;

    localparam int instrWidth  = 16;
    localparam int regSelWidth = 4;

    // instruction field positions
    localparam int condLsb  = 13;           // 3-bit condition code
    localparam int destLsb  = 12;           // destination register
    localparam int srcLsb   = 8;            // source register
    localparam int pairLsb  = 9;            // register pair, 3 bits
    localparam int subOpLsb = 3;            // 5-bit sub-opcode

    typedef logic [instrWidth-1:0]  instr_t;
    typedef logic [regSelWidth-1:0] regSel_t;

    localparam regSel_t spLowReg = 4'd14;   // low byte of stack pointer

    typedef enum logic [3:0] {
        opAluImm,
        opAluReg,
        opIn,
        opOut,
        opStore,
        opLoad,
        opJmp,
        opCall,
        opRet,
        opHlt,
        opNop
    } opcode_t;

    typedef enum logic [1:0] {
        stepNone = 2'd0,
        stepInc  = 2'd1,
        stepDec  = 2'd2
    } pairStep_t;

    typedef enum logic [3:0] {
        passB  = 4'd0,
        aluAnd = 4'd1,
        aluOr  = 4'd2,
        aluXor = 4'd3,
        aluAdd = 4'd4,
        aluAdc = 4'd5,
        aluSub = 4'd6,
        aluSbc = 4'd7,
        aluInc = 4'd8,
        aluDec = 4'd9,
        aluShl = 4'd10,
        aluShr = 4'd11,
        aluNot = 4'd12,
        passA  = 4'd13
    } aluMode_t;

    typedef enum logic {srcBReg, srcBImm8} aluSrcB_t;

    typedef enum logic [1:0] {
        dataPcHigh = 2'd0,
        dataPcLow  = 2'd1,
        dataAluOut = 2'd2
    } dMemData_t;

    typedef enum logic {addrRegPair, addrPortImm} dMemAddr_t;

    typedef enum logic [1:0] {iAddrPcPlusOne, iAddrPcOut, iAddrIMemOut} iMemAddr_t;

    typedef enum logic [1:0] {stFetch, stReadWait, stJumpTarget, stCallHigh} seqState_t;

endpackage

`default_nettype wire

//--- instrDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecode (
    input  cpuCtrlPkg::instr_t    iMemOut,
    output cpuCtrlPkg::opcode_t   opcode,
    output cpuCtrlPkg::aluMode_t  aluMode,
    output cpuCtrlPkg::regSel_t   destSel,
    output cpuCtrlPkg::regSel_t   srcSel,
    output cpuCtrlPkg::regSel_t   pairSel,
    output cpuCtrlPkg::pairStep_t pairStep
);

    logic [4:0] subOp;
    logic [2:0] lowBits;
    logic [2:0] immAluCode;

    // offset within a store or load group picks the pair step
    function automatic cpuCtrlPkg::pairStep_t stepOf(input logic [4:0] offset);
        cpuCtrlPkg::pairStep_t step;
        case (offset)
            5'd1:    step = cpuCtrlPkg::stepInc;
            5'd2:    step = cpuCtrlPkg::stepDec;
            default: step = cpuCtrlPkg::stepNone;
        endcase
        return step;
    endfunction

    assign subOp      = iMemOut[cpuCtrlPkg::subOpLsb +: 5];
    assign lowBits    = iMemOut[2:0];
    assign immAluCode = iMemOut[3:1];

    assign destSel = iMemOut[cpuCtrlPkg::destLsb +: 4];
    assign srcSel  = iMemOut[cpuCtrlPkg::srcLsb +: 4];
    assign pairSel = {iMemOut[cpuCtrlPkg::pairLsb +: 3], 1'b0};  // pair index times two

    always_comb begin
        opcode   = cpuCtrlPkg::opNop;
        aluMode  = cpuCtrlPkg::passB;
        pairStep = cpuCtrlPkg::stepNone;

        if (iMemOut[0] && immAluCode != 3'b111) begin
            opcode  = cpuCtrlPkg::opAluImm;
            aluMode = cpuCtrlPkg::aluMode_t'({1'b0, immAluCode});
        end else if (lowBits == 3'b010) begin
            opcode = cpuCtrlPkg::opIn;
        end else if (lowBits == 3'b100) begin
            opcode = cpuCtrlPkg::opOut;
        end else if (lowBits == 3'b000) begin
            case (subOp) inside
                [5'd1:5'd12]: begin                     // register-register alu
                    opcode  = cpuCtrlPkg::opAluReg;
                    aluMode = cpuCtrlPkg::aluMode_t'(subOp[3:0]);
                end
                [5'd13:5'd15]: begin
                    opcode   = cpuCtrlPkg::opStore;
                    aluMode  = cpuCtrlPkg::passA;
                    pairStep = stepOf(subOp - 5'd13);
                end
                [5'd16:5'd18]: begin
                    opcode   = cpuCtrlPkg::opLoad;
                    aluMode  = cpuCtrlPkg::passA;
                    pairStep = stepOf(subOp - 5'd16);
                end
                5'd22: begin
                    opcode = cpuCtrlPkg::opJmp;
                end
                5'd23: begin
                    opcode = cpuCtrlPkg::opCall;
                end
                5'd24: begin
                    opcode = cpuCtrlPkg::opRet;
                end
                5'd29: begin
                    opcode = cpuCtrlPkg::opHlt;
                end
                default: begin
                    opcode = cpuCtrlPkg::opNop;         // unused sub-opcodes
                end
            endcase
        end
    end

endmodule

`default_nettype wire
